// File: hdl/spi_link_pkg.sv
`default_nettype none

package spi_link_pkg;

  // Frame and serial clock
  localparam int FRAME_BITS = 8;                   // Bits per SPI frame
  localparam int SPI_DIV    = 4;                   // sclk cycles per spi_clk half period
  localparam int BIT_CNT_W  = $clog2(FRAME_BITS);  // Bit index width
  localparam int DIV_CNT_W  = $clog2(SPI_DIV);     // Divider counter width

  // Reply buffer
  localparam int FIFO_DEPTH = 4;                   // Reply entries
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);  // Pointer width, depth is a power of two

  // Command byte layout
  localparam logic [FRAME_BITS-1:0] CMD_ID   = 8'h8F;  // Identity request
  localparam logic [FRAME_BITS-1:0] ID_REPLY = 8'hAA;  // Identity answer
  localparam int CMD_READ_BIT = 0;                 // Read flag
  localparam int SEL_HI       = 6;                 // Byte select, upper bit
  localparam int SEL_LO       = 5;                 // Byte select, lower bit

endpackage

`default_nettype wire

// File: hdl/reply_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module reply_fifo (
  input  wire                                 sclk,
  input  wire                                 rst_n,
  input  wire                                 push,       // Dropped when full
  input  wire  [spi_link_pkg::FRAME_BITS-1:0] push_data,
  input  wire                                 rd_en,      // Ignored when empty
  output logic [spi_link_pkg::FRAME_BITS-1:0] rd_data,    // Head entry
  output logic                                empty,
  output logic                                full
);

  import spi_link_pkg::*;

  logic [FRAME_BITS-1:0] mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_PTR_W:0]   count;   // Occupancy, 0 to FIFO_DEPTH
  logic                  do_push;
  logic                  do_read;

  assign empty   = (count == '0);
  assign full    = (count == (FIFO_PTR_W+1)'(FIFO_DEPTH));
  assign do_push = push & ~full;
  assign do_read = rd_en & ~empty;
  assign rd_data = mem[rd_ptr];  // Show-ahead read

  // Storage
  always_ff @(posedge sclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap naturally
  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_read) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/spi_peripheral.sv
`timescale 1ns/1ps
`default_nettype none

module spi_peripheral (
  input  wire                                 sclk,
  input  wire                                 rst_n,
  input  wire                                 ss_n,         // Active low select
  input  wire                                 spi_clk,
  input  wire                                 mosi,
  input  wire  [31:0]                         config_word,  // Source of read replies
  output logic                                miso,
  output logic [spi_link_pkg::FRAME_BITS-1:0] last_cmd
);

  import spi_link_pkg::*;

  logic                  spi_clk_q1;  // spi_clk delayed one sclk
  logic                  spi_clk_q2;  // and two
  logic                  rise;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [FRAME_BITS-1:0] rx_sr;       // Incoming command bits
  logic [FRAME_BITS-1:0] tx_sr;       // Outgoing reply bits
  logic [FRAME_BITS-1:0] cmd_next;    // Full command on the last bit
  logic [FRAME_BITS-1:0] reply_next;

  assign rise     = spi_clk_q1 & ~spi_clk_q2;
  assign miso     = tx_sr[FRAME_BITS-1];  // MSB first
  assign cmd_next = {rx_sr[FRAME_BITS-2:0], mosi};

  // Reply decode
  always_comb begin
    if (cmd_next == CMD_ID) begin
      reply_next = ID_REPLY;
    end else if (cmd_next[CMD_READ_BIT]) begin
      case (cmd_next[SEL_HI:SEL_LO])  // Pick one config byte
        2'd0:    reply_next = config_word[7:0];
        2'd1:    reply_next = config_word[15:8];
        2'd2:    reply_next = config_word[23:16];
        default: reply_next = config_word[31:24];
      endcase
    end else begin
      reply_next = '0;  // Write or unknown command
    end
  end

  // Edge detect
  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      spi_clk_q1 <= 1'b0;
      spi_clk_q2 <= 1'b0;
    end else begin
      spi_clk_q1 <= spi_clk;
      spi_clk_q2 <= spi_clk_q1;
    end
  end

  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      bit_cnt  <= '0;
      tx_sr    <= '0;  // First frame answers zero
      last_cmd <= '0;
    end else if (ss_n) begin
      bit_cnt <= '0;   // Deselected, realign to next frame
    end else if (rise) begin
      bit_cnt <= bit_cnt + 1'b1;  // Wraps after the last bit
      if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1)) begin
        last_cmd <= cmd_next;
        tx_sr    <= reply_next;   // Goes out on the next frame
      end else begin
        tx_sr <= {tx_sr[FRAME_BITS-2:0], 1'b0};  // Host already took this bit
      end
    end
  end

  // Receive shift
  always_ff @(posedge sclk) begin
    if (!ss_n && rise) begin
      rx_sr <= cmd_next;
    end
  end

endmodule

`default_nettype wire

// File: hdl/spi_controller.sv
`timescale 1ns/1ps
`default_nettype none

module spi_controller (
  input  wire                                 sclk,
  input  wire                                 rst_n,
  input  wire                                 cmd_valid,   // One-cycle command strobe
  input  wire  [spi_link_pkg::FRAME_BITS-1:0] cmd_byte,
  input  wire                                 miso,
  output logic                                spi_clk,     // Idles low
  output logic                                ss_n,
  output logic                                mosi,
  output logic                                busy,
  output logic                                push,        // Reply byte valid for one cycle
  output logic [spi_link_pkg::FRAME_BITS-1:0] reply_byte
);

  import spi_link_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SHIFT,
    ST_FINISH
  } state_t;

  state_t                 state;
  logic [DIV_CNT_W-1:0]   div_cnt;   // Half period counter
  logic [BIT_CNT_W:0]     bit_cnt;   // Rising edges seen, up to FRAME_BITS
  logic [FRAME_BITS-1:0]  tx_sr;     // Bits still to send
  logic [FRAME_BITS-1:0]  rx_sr;     // Bits captured from miso
  logic                   half_done; // spi_clk toggles this cycle

  assign half_done = (div_cnt == DIV_CNT_W'(SPI_DIV - 1));

  // Control path
  always_ff @(posedge sclk) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      spi_clk <= 1'b0;
      ss_n    <= 1'b1;
      mosi    <= 1'b0;
      busy    <= 1'b0;
      push    <= 1'b0;
    end else begin
      push <= 1'b0;  // Strobe by default
      case (state)
        ST_IDLE: begin
          if (cmd_valid) begin           // busy is low in this state
            state   <= ST_SHIFT;
            ss_n    <= 1'b0;             // Select for the whole frame
            busy    <= 1'b1;
            mosi    <= cmd_byte[FRAME_BITS-1];  // First bit goes out with select
            div_cnt <= '0;
            bit_cnt <= '0;
          end
        end
        ST_SHIFT: begin
          if (half_done) begin
            div_cnt <= '0;
            spi_clk <= ~spi_clk;
            if (!spi_clk) begin
              bit_cnt <= bit_cnt + 1'b1;  // Rising edge, miso sampled below
            end else if (bit_cnt == (BIT_CNT_W+1)'(FRAME_BITS)) begin
              state <= ST_FINISH;         // Last low phase begins
            end else begin
              mosi <= tx_sr[FRAME_BITS-1];  // Next bit after the falling edge
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        ST_FINISH: begin
          state <= ST_IDLE;
          ss_n  <= 1'b1;
          mosi  <= 1'b0;
          busy  <= 1'b0;  // Falls with push
          push  <= 1'b1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Data path
  always_ff @(posedge sclk) begin
    if (state == ST_IDLE && cmd_valid) begin
      tx_sr <= {cmd_byte[FRAME_BITS-2:0], 1'b0};  // MSB already on mosi
    end else if (state == ST_SHIFT && half_done) begin
      if (!spi_clk) begin
        rx_sr <= {rx_sr[FRAME_BITS-2:0], miso};    // Sample on rising edge
      end else begin
        tx_sr <= {tx_sr[FRAME_BITS-2:0], 1'b0};
      end
    end
    if (state == ST_FINISH) begin
      reply_byte <= rx_sr;  // Held with push
    end
  end

endmodule

`default_nettype wire

// File: hdl/spi_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_link_top (
  input  wire                                 sclk,
  input  wire                                 rst_n,
  input  wire                                 cmd_valid,
  input  wire  [spi_link_pkg::FRAME_BITS-1:0] cmd_byte,
  output logic                                busy,
  input  wire  [31:0]                         config_word,
  output logic [spi_link_pkg::FRAME_BITS-1:0] last_cmd,
  input  wire                                 rd_en,
  output logic [spi_link_pkg::FRAME_BITS-1:0] rd_data,
  output logic                                empty,
  output logic                                full
);

  import spi_link_pkg::*;

  // Serial lines stay inside
  logic                  spi_clk;
  logic                  ss_n;
  logic                  mosi;
  logic                  miso;
  logic                  push;
  logic [FRAME_BITS-1:0] reply_byte;

  spi_controller u_controller (
    .sclk       (sclk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_byte   (cmd_byte),
    .miso       (miso),
    .spi_clk    (spi_clk),
    .ss_n       (ss_n),
    .mosi       (mosi),
    .busy       (busy),
    .push       (push),
    .reply_byte (reply_byte)
  );

  spi_peripheral u_peripheral (
    .sclk        (sclk),
    .rst_n       (rst_n),
    .ss_n        (ss_n),
    .spi_clk     (spi_clk),
    .mosi        (mosi),
    .config_word (config_word),
    .miso        (miso),
    .last_cmd    (last_cmd)
  );

  // Replies wait here for the host
  reply_fifo u_fifo (
    .sclk      (sclk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (reply_byte),
    .rd_en     (rd_en),
    .rd_data   (rd_data),
    .empty     (empty),
    .full      (full)
  );

endmodule

`default_nettype wire

// File: sim/tb_spi_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_link;

  import spi_link_pkg::*;

  localparam int RESET_CYCLES   = 16;
  localparam int NUM_ENTRIES    = 20;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * (2 * FRAME_BITS * SPI_DIV + 20) + RESET_CYCLES;

  logic                  sclk = 1'b0;
  logic                  rst_n;
  logic                  cmd_valid;
  logic [FRAME_BITS-1:0] cmd_byte;
  logic                  busy;
  logic [31:0]           config_word;
  logic [FRAME_BITS-1:0] last_cmd;
  logic                  rd_en;
  logic [FRAME_BITS-1:0] rd_data;
  logic                  empty;
  logic                  full;

  // Entry layout {poke, drain, cmd}
  logic [FRAME_BITS+1:0] stim [NUM_ENTRIES];
  logic [FRAME_BITS-1:0] exp_q [$];    // Replies the FIFO should hold
  logic [FRAME_BITS-1:0] pending;      // Answer to the last accepted command
  logic [31:0]           rng_state;
  int                    errors;
  int                    frames;
  int                    cycle_cnt = 0;
  int                    idx;

  always #5 sclk = ~sclk;  // 10 ns period

  spi_link_top u_spi_link_top (
    .sclk        (sclk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd_byte    (cmd_byte),
    .busy        (busy),
    .config_word (config_word),
    .last_cmd    (last_cmd),
    .rd_en       (rd_en),
    .rd_data     (rd_data),
    .empty       (empty),
    .full        (full)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Expected answer to one command
  function automatic logic [FRAME_BITS-1:0] reply_of(input logic [FRAME_BITS-1:0] cmd,
                                                     input logic [31:0] cfg);
    logic [1:0]  sel;
    logic [31:0] shifted;
    sel     = cmd[SEL_HI:SEL_LO];
    shifted = cfg >> (8 * sel);        // Selected byte lands at the bottom
    if (cmd == CMD_ID) return ID_REPLY;
    if (cmd[CMD_READ_BIT]) return shifted[7:0];
    return '0;
  endfunction

  task automatic load_stimulus();
    stim[0]  = {1'b0, 1'b1, 8'h8F};  // Identity, first reply is zero
    stim[1]  = {1'b0, 1'b1, 8'h01};  // Gets AA, read sel 0
    stim[2]  = {1'b0, 1'b1, 8'h21};  // Read sel 1
    stim[3]  = {1'b0, 1'b1, 8'h41};  // Read sel 2
    stim[4]  = {1'b0, 1'b1, 8'h61};  // Read sel 3
    stim[5]  = {1'b0, 1'b1, 8'h02};  // Write
    stim[6]  = {1'b0, 1'b1, 8'h8F};
    stim[7]  = {1'b0, 1'b1, 8'h10};
    stim[8]  = {1'b0, 1'b1, 8'hE1};
    stim[9]  = {1'b0, 1'b1, 8'h8E};  // Close to identity but read bit clear
    stim[10] = {1'b0, 1'b0, 8'h8D};  // Six frames without reading
    stim[11] = {1'b0, 1'b0, 8'h8F};
    stim[12] = {1'b0, 1'b0, 8'h33};
    stim[13] = {1'b1, 1'b0, 8'h5A};  // FIFO full after this one
    stim[14] = {1'b0, 1'b0, 8'h45};  // Dropped
    stim[15] = {1'b0, 1'b1, 8'h7F};  // Dropped, then drain
    stim[16] = {1'b1, 1'b1, 8'hC1};  // Stray strobe mid frame
    stim[17] = {1'b0, 1'b1, 8'h00};
    stim[18] = {1'b1, 1'b1, 8'h8F};
    stim[19] = {1'b0, 1'b1, 8'h00};
  endtask

  // One SPI frame, returns after the reply reached the FIFO
  task automatic run_frame(input logic [FRAME_BITS-1:0] cmd, input logic poke);
    @(posedge sclk);
    rng_state = xorshift32(rng_state);
    cmd_valid   <= 1'b1;
    cmd_byte    <= cmd;
    config_word <= rng_state;        // Fresh config for every frame
    @(posedge sclk);
    cmd_valid <= 1'b0;
    @(negedge sclk);
    if (!busy) begin
      $display("Command 0x%02h was not accepted, busy stayed low", cmd);
      errors++;
    end
    if (poke) begin
      @(posedge sclk);
      cmd_valid <= 1'b1;             // Must be ignored
      cmd_byte  <= ~cmd;
      @(posedge sclk);
      cmd_valid <= 1'b0;
      @(negedge sclk);
    end
    while (busy) @(negedge sclk);    // Frame ends when busy falls
    if (last_cmd !== cmd) begin
      $display("[FAIL] %0t: last_cmd 0x%02h, expected 0x%02h", $time, last_cmd, cmd);
      errors++;
    end
    @(negedge sclk);                 // push lands in the FIFO
  endtask

  task automatic drain_fifo();
    logic [FRAME_BITS-1:0] want;
    while (exp_q.size() > 0) begin
      want = exp_q.pop_front();
      if (empty) begin
        $display("[FAIL] %0t: FIFO empty, %0d replies still expected", $time, exp_q.size() + 1);
        errors++;
      end
      if (rd_data !== want) begin
        $display("[FAIL] %0t: reply 0x%02h, expected 0x%02h", $time, rd_data, want);
        errors++;
      end
      @(posedge sclk);
      rd_en <= 1'b1;
      @(posedge sclk);
      rd_en <= 1'b0;
      @(negedge sclk);
    end
    if (!empty) begin
      $display("[FAIL] %0t: FIFO not empty after drain", $time);
      errors++;
    end
  endtask

  // Watchdog
  always @(posedge sclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    rst_n       <= 1'b0;
    cmd_valid   <= 1'b0;
    cmd_byte    <= '0;
    config_word <= '0;
    rd_en       <= 1'b0;
    errors      = 0;
    frames      = 0;
    pending     = '0;               // Nothing answered before the first frame
    rng_state   = 32'd45;
    load_stimulus();

    repeat (RESET_CYCLES) @(posedge sclk);
    rst_n <= 1'b1;
    @(negedge sclk);
    if (empty !== 1'b1 || full !== 1'b0 || last_cmd !== '0) begin
      $display("[FAIL] %0t: reset state empty=%b full=%b last_cmd=0x%02h",
               $time, empty, full, last_cmd);
      errors++;
    end

    for (idx = 0; idx < NUM_ENTRIES; idx++) begin
      run_frame(stim[idx][FRAME_BITS-1:0], stim[idx][FRAME_BITS+1]);
      frames++;
      if (exp_q.size() < FIFO_DEPTH) exp_q.push_back(pending);  // Else dropped
      pending = reply_of(stim[idx][FRAME_BITS-1:0], config_word);
      if (full !== (exp_q.size() == FIFO_DEPTH)) begin
        $display("[FAIL] %0t: full=%b with %0d replies queued", $time, full, exp_q.size());
        errors++;
      end
      if (empty !== (exp_q.size() == 0)) begin
        $display("[FAIL] %0t: empty=%b with %0d replies queued", $time, empty, exp_q.size());
        errors++;
      end
      if (stim[idx][FRAME_BITS]) drain_fifo();
    end

    $display("Frames run: %0d, errors: %0d", frames, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
hdl/spi_link_pkg.sv
hdl/reply_fifo.sv
hdl/spi_peripheral.sv
hdl/spi_controller.sv
hdl/spi_link_top.sv
sim/tb_spi_link.sv

// File: Makefile
obj_dir/Vtb_spi_link: src.f $(wildcard hdl/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --top-module tb_spi_link -f src.f -o Vtb_spi_link

run: obj_dir/Vtb_spi_link
	./obj_dir/Vtb_spi_link | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
